/* dual_ex.f */
src/dual_ex_pkg.sv
src/issue_port.sv
src/main_alu.sv
src/deputy_alu.sv
src/execute_stage.sv
src/result_port.sv
src/dual_ex_top.sv
sim/dual_ex_checker.sv
sim/dual_ex_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dual_ex_tb -f dual_ex.f \
    && ./obj_dir/Vdual_ex_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && exit 0 || exit 1

/* sim/dual_ex_checker.sv */
`timescale 1ns/1ps

module dual_ex_checker (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  issue_req_i,
    input logic                  issue_ack_o,
    input logic                  res_req_o,
    input logic                  res_ack_i,
    input dual_ex_pkg::op_pair_t pair_i
);

    logic two_muls;

    assign two_muls = pair_i[0].valid && (pair_i[0].op == dual_ex_pkg::MUL)
                   && pair_i[1].valid && (pair_i[1].op == dual_ex_pkg::MUL);

    // ack only answers a pending request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n_i) $rose(issue_ack_o) |-> issue_req_i
    ) else $error("issue_ack_o rose while issue_req_i was low");

    // sender keeps req up until the sink answers
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i) (res_req_o && !res_ack_i) |=> res_req_o
    ) else $error("res_req_o dropped before res_ack_i");

    one_mul_per_pair: assert property (
        @(posedge clk) disable iff (!rst_n_i) issue_req_i |-> !two_muls
    ) else $error("issued pair holds two valid MUL ops");

endmodule

/* sim/dual_ex_tb.sv */
`timescale 1ns/1ps

module dual_ex_tb;

    localparam int LIMIT = 200;

    logic                      clk;
    logic                      rst_n_i;
    logic                      issue_req_i;
    logic                      issue_ack_o;
    logic                      res_req_o;
    logic                      res_ack_i;
    dual_ex_pkg::op_pair_t     pair_i;
    dual_ex_pkg::result_pair_t res_o;
    dual_ex_pkg::result_pair_t exp_q[$];
    int                        errors;
    int                        timeouts;
    int                        max_delay;
    logic                      sink_en = 1'b0;
    logic                      sink_busy = 1'b0;

    dual_ex_top #(.DATA_W(32)) dut_i (.*);

    bind dual_ex_top dual_ex_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic dual_ex_pkg::ex_result_t exec_slot(dual_ex_pkg::ex_op_t op);
        dual_ex_pkg::ex_result_t r;
        r.dest  = op.dest;
        r.valid = op.valid && (op.op inside {dual_ex_pkg::ADD, dual_ex_pkg::SUB,
            dual_ex_pkg::AND, dual_ex_pkg::OR, dual_ex_pkg::XOR, dual_ex_pkg::SLL,
            dual_ex_pkg::SRL, dual_ex_pkg::SLT, dual_ex_pkg::MUL});
        case (op.op)
            dual_ex_pkg::ADD: r.value = op.src_a + op.src_b;
            dual_ex_pkg::SUB: r.value = op.src_a - op.src_b;
            dual_ex_pkg::AND: r.value = op.src_a & op.src_b;
            dual_ex_pkg::OR:  r.value = op.src_a | op.src_b;
            dual_ex_pkg::XOR: r.value = op.src_a ^ op.src_b;
            dual_ex_pkg::SLL: r.value = op.src_a << op.src_b[4:0];
            dual_ex_pkg::SRL: r.value = op.src_a >> op.src_b[4:0];
            dual_ex_pkg::SLT: r.value = ($signed(op.src_a) < $signed(op.src_b)) ? 32'd1 : 32'd0;
            dual_ex_pkg::MUL: r.value = op.src_a * op.src_b;
            default:          r.value = '0;
        endcase
        return r;
    endfunction

    function automatic logic is_taken(dual_ex_pkg::ex_op_t op);
        case (op.op)
            dual_ex_pkg::BEQ: return op.valid && (op.src_a == op.src_b);
            dual_ex_pkg::BNE: return op.valid && (op.src_a != op.src_b);
            dual_ex_pkg::BLT: return op.valid && ($signed(op.src_a) < $signed(op.src_b));
            default:          return 1'b0;
        endcase
    endfunction

    function automatic dual_ex_pkg::result_pair_t expected_result(dual_ex_pkg::op_pair_t p);
        dual_ex_pkg::result_pair_t e;
        dual_ex_pkg::ex_op_t       m;
        dual_ex_pkg::ex_op_t       d;
        logic                      mt;
        logic                      dt;
        logic                      m_wins;
        m = (p[1].valid && p[1].op == dual_ex_pkg::MUL) ? p[1] : p[0];
        d = (p[1].valid && p[1].op == dual_ex_pkg::MUL) ? p[0] : p[1];
        e.main_res   = exec_slot(m);
        e.deputy_res = exec_slot(d);
        mt = is_taken(m);
        dt = is_taken(d);
        m_wins = mt && (!dt || m.pc < d.pc);
        e.redirect_valid = mt || dt;
        e.redirect_pc    = m_wins ? m.pc + m.imm : d.pc + d.imm;
        if (m_wins && d.pc > m.pc) begin
            e.deputy_res.valid = 1'b0;
        end
        if (!m_wins && dt && m.pc > d.pc) begin
            e.main_res.valid = 1'b0;
        end
        return e;
    endfunction

    function automatic dual_ex_pkg::ex_op_t make_op(dual_ex_pkg::op_e code, dual_ex_pkg::pc_t pc,
                                                    dual_ex_pkg::word_t a, dual_ex_pkg::word_t b);
        dual_ex_pkg::ex_op_t o;
        o.valid = 1'b1;
        o.op    = code;
        o.pc    = pc;
        o.src_a = a;
        o.src_b = b;
        o.imm   = dual_ex_pkg::word_t'($urandom_range(1, 255)) << 2;
        o.dest  = dual_ex_pkg::reg_tag_t'($urandom);
        return o;
    endfunction

    function automatic dual_ex_pkg::ex_op_t rand_alu(dual_ex_pkg::pc_t pc);
        return make_op(dual_ex_pkg::op_e'($urandom_range(0, 7)), pc, $urandom, $urandom);
    endfunction

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_result(input dual_ex_pkg::result_pair_t e,
                                input dual_ex_pkg::result_pair_t g);
        compare_field("main valid", 32'(g.main_res.valid), 32'(e.main_res.valid));
        if (e.main_res.valid) begin
            compare_field("main dest", 32'(g.main_res.dest), 32'(e.main_res.dest));
            compare_field("main value", g.main_res.value, e.main_res.value);
        end
        compare_field("deputy valid", 32'(g.deputy_res.valid), 32'(e.deputy_res.valid));
        if (e.deputy_res.valid) begin
            compare_field("deputy dest", 32'(g.deputy_res.dest), 32'(e.deputy_res.dest));
            compare_field("deputy value", g.deputy_res.value, e.deputy_res.value);
        end
        compare_field("redirect valid", 32'(g.redirect_valid), 32'(e.redirect_valid));
        if (e.redirect_valid) begin
            compare_field("redirect pc", g.redirect_pc, e.redirect_pc);
        end
    endtask

    // four-phase issue handshake
    task automatic send_pair(input dual_ex_pkg::op_pair_t p);
        int cnt;
        exp_q.push_back(expected_result(p));
        pair_i      <= p;
        issue_req_i <= 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!issue_ack_o && cnt < LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (!issue_ack_o) begin
            note_timeout("issue_ack_o never rose");
        end
        issue_req_i <= 1'b0;
        cnt = 0;
        while (issue_ack_o && cnt < LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (issue_ack_o) begin
            note_timeout("issue_ack_o never dropped");
        end
    endtask

    task automatic ack_result();
        int cnt;
        res_ack_i <= 1'b1;
        cnt = 0;
        while (res_req_o && cnt < LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (res_req_o) begin
            note_timeout("res_req_o never dropped after ack");
        end
        res_ack_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while ((exp_q.size() != 0 || sink_busy) && cnt < 10 * LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (exp_q.size() != 0 || sink_busy) begin
            note_timeout("result packets still outstanding");
            exp_q.delete();
        end
    endtask

    // sink compares every packet with the oldest expected one
    initial begin : compare_proc
        int cnt;
        forever begin
            cnt = 0;
            sink_busy = 1'b0;
            while (!(sink_en && res_req_o)) begin
                @(posedge clk);
                if (sink_en && exp_q.size() != 0) begin
                    cnt++;
                end
                if (cnt == LIMIT) begin
                    note_timeout("no result packet arrived");
                    exp_q.delete();
                    cnt = 0;
                end
            end
            sink_busy = 1'b1;
            repeat ($urandom_range(0, max_delay)) @(posedge clk);
            if (exp_q.size() == 0) begin
                errors++;
                $display("FAILED at %0t: result packet arrived with none expected", $time);
            end else begin
                check_result(exp_q.pop_front(), res_o);
            end
            ack_result();
        end
    end

    initial begin : main_proc
        dual_ex_pkg::op_pair_t p;
        int                    cnt;
        int                    slot;
        errors    = 0;
        timeouts  = 0;
        max_delay = 3;
        void'($urandom(32'hf958_7160));
        rst_n_i     = 1'b0;
        issue_req_i = 1'b0;
        res_ack_i   = 1'b0;
        pair_i      = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        sink_en = 1'b1;
        @(posedge clk);

        repeat (20) begin
            p[0] = rand_alu(32'h100);
            p[1] = rand_alu(32'h104);
            send_pair(p);
        end

        // MUL in slot 0, then in slot 1
        p[0] = make_op(dual_ex_pkg::MUL, 32'h200, $urandom, $urandom);
        p[1] = rand_alu(32'h204);
        send_pair(p);
        p[0] = rand_alu(32'h300);
        p[1] = make_op(dual_ex_pkg::MUL, 32'h304, $urandom, $urandom);
        send_pair(p);

        // single taken branches against the pc rule
        p[0] = make_op(dual_ex_pkg::BEQ, 32'h400, 5, 5);
        p[1] = rand_alu(32'h404);
        send_pair(p);
        p[0] = rand_alu(32'h504);
        p[1] = make_op(dual_ex_pkg::BNE, 32'h500, 1, 2);
        send_pair(p);
        p[0] = rand_alu(32'h600);
        p[1] = make_op(dual_ex_pkg::BLT, 32'h604, -1, 1);
        send_pair(p);
        p[0] = make_op(dual_ex_pkg::BEQ, 32'h700, 3, 3);
        p[1] = make_op(dual_ex_pkg::MUL, 32'h704, $urandom, $urandom);
        send_pair(p);

        // both taken with either pipe older, then both not taken
        p[0] = make_op(dual_ex_pkg::BNE, 32'h808, 1, 2);
        p[1] = make_op(dual_ex_pkg::BLT, 32'h800, -5, 2);
        send_pair(p);
        p[0] = make_op(dual_ex_pkg::BEQ, 32'h840, 4, 4);
        p[1] = make_op(dual_ex_pkg::BNE, 32'h844, 0, 1);
        send_pair(p);
        p[0] = make_op(dual_ex_pkg::BEQ, 32'h900, 1, 2);
        p[1] = make_op(dual_ex_pkg::BLT, 32'h904, 7, 3);
        send_pair(p);
        drain();

        // slow sink, back-to-back issue
        max_delay = 15;
        repeat (12) begin
            p[0] = rand_alu(32'ha00);
            p[1] = rand_alu(32'ha04);
            if ($urandom_range(0, 2) == 0) begin
                slot = $urandom_range(0, 1);
                p[slot] = make_op(dual_ex_pkg::MUL, 32'ha00 + 32'(slot * 4), $urandom, $urandom);
            end
            send_pair(p);
        end
        drain();

        // reset with packets stuck in the pipe and an issue ack still up
        max_delay = 3;
        sink_en = 1'b0;
        p[0] = rand_alu(32'hb00);
        p[1] = rand_alu(32'hb04);
        send_pair(p);
        send_pair(p);
        pair_i      <= p;
        issue_req_i <= 1'b1;
        cnt = 0;
        while (!(issue_ack_o && res_req_o) && cnt < LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (!(issue_ack_o && res_req_o)) begin
            note_timeout("issue_ack_o and res_req_o never both high before reset");
        end
        rst_n_i     <= 1'b0;
        issue_req_i <= 1'b0;
        @(posedge clk);
        if (issue_ack_o !== 1'b0 || res_req_o !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: handshake outputs not cleared by reset", $time);
        end
        exp_q.delete();
        @(posedge clk);
        rst_n_i <= 1'b1;
        sink_en = 1'b1;
        @(posedge clk);
        p[0] = rand_alu(32'hc00);
        p[1] = make_op(dual_ex_pkg::MUL, 32'hc04, $urandom, $urandom);
        send_pair(p);
        drain();

        $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* src/deputy_alu.sv */
`timescale 1ns/1ps

module deputy_alu #(
    parameter int DATA_W = dual_ex_pkg::DATA_W_DEFAULT
) (
    input  dual_ex_pkg::ex_op_t     op_i,
    output dual_ex_pkg::ex_result_t result_o,
    output logic                    taken_o,
    output dual_ex_pkg::pc_t        target_o
);

    localparam int SHAMT_W = $clog2(DATA_W);

    dual_ex_pkg::word_t shamt;
    logic               writes;

    assign shamt = dual_ex_pkg::word_t'(op_i.src_b[SHAMT_W-1:0]);

    // a stray MUL writes nothing since this pipe has no multiplier
    assign writes = op_i.valid && dual_ex_pkg::is_alu_op(op_i.op);

    always_comb begin
        result_o.valid = writes;
        result_o.dest  = op_i.dest;
        result_o.value = dual_ex_pkg::alu_calc(op_i.op, op_i.src_a, op_i.src_b, shamt);
    end

    assign taken_o  = op_i.valid && dual_ex_pkg::branch_cond(op_i.op, op_i.src_a, op_i.src_b);
    assign target_o = op_i.pc + op_i.imm;

endmodule

/* src/dual_ex_pkg.sv */
package dual_ex_pkg;

    localparam int DATA_W_DEFAULT = 32;

    typedef logic [DATA_W_DEFAULT-1:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0] reg_tag_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT,
        BEQ, BNE, BLT,
        MUL,
        NOP
    } op_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        WAIT_ACK,
        WAIT_DROP
    } pipe_state_e;

    typedef struct packed {
        logic     valid;
        op_e      op;
        pc_t      pc;
        word_t    src_a;
        word_t    src_b;
        word_t    imm;
        reg_tag_t dest;
    } ex_op_t;

    // slot 0 is the first-fetched op
    typedef ex_op_t [1:0] op_pair_t;

    typedef struct packed {
        logic     valid;
        reg_tag_t dest;
        word_t    value;
    } ex_result_t;

    typedef struct packed {
        ex_result_t main_res;
        ex_result_t deputy_res;
        logic       redirect_valid;
        pc_t        redirect_pc;
    } result_pair_t;

    function automatic logic is_alu_op(op_e op);
        return op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SLT};
    endfunction

    // shamt is already cut down to the shift range by the caller
    function automatic word_t alu_calc(op_e op, word_t a, word_t b, word_t shamt);
        word_t res;
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            SLL:     res = a << shamt;
            SRL:     res = a >> shamt;
            SLT:     res = word_t'($signed(a) < $signed(b));
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic branch_cond(op_e op, word_t a, word_t b);
        logic cond;
        case (op)
            BEQ:     cond = (a == b);
            BNE:     cond = (a != b);
            BLT:     cond = ($signed(a) < $signed(b));
            default: cond = 1'b0;
        endcase
        return cond;
    endfunction

endpackage

/* src/dual_ex_top.sv */
`timescale 1ns/1ps

module dual_ex_top #(
    parameter int DATA_W = 32
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      issue_req_i,
    input  dual_ex_pkg::op_pair_t     pair_i,
    output logic                      issue_ack_o,
    output logic                      res_req_o,
    output dual_ex_pkg::result_pair_t res_o,
    input  logic                      res_ack_i
);

    dual_ex_pkg::op_pair_t     pair;
    dual_ex_pkg::result_pair_t res;
    logic                      pair_valid;
    logic                      pair_ready;
    logic                      res_valid;
    logic                      res_ready;

    issue_port u_issue_port (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_req_i  (issue_req_i),
        .pair_i       (pair_i),
        .pair_ready_i (pair_ready),
        .issue_ack_o  (issue_ack_o),
        .pair_valid_o (pair_valid),
        .pair_o       (pair)
    );

    execute_stage #(.DATA_W(DATA_W)) u_execute_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pair_valid_i (pair_valid),
        .pair_i       (pair),
        .res_ready_i  (res_ready),
        .pair_ready_o (pair_ready),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

    result_port u_result_port (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .res_valid_i (res_valid),
        .res_i       (res),
        .res_ack_i   (res_ack_i),
        .res_ready_o (res_ready),
        .res_req_o   (res_req_o),
        .res_o       (res_o)
    );

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
    parameter int DATA_W = dual_ex_pkg::DATA_W_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      pair_valid_i,
    input  dual_ex_pkg::op_pair_t     pair_i,
    input  logic                      res_ready_i,
    output logic                      pair_ready_o,
    output logic                      res_valid_o,
    output dual_ex_pkg::result_pair_t res_o
);

    dual_ex_pkg::op_pair_t     cur_pair;
    dual_ex_pkg::op_pair_t     hold_q;
    dual_ex_pkg::ex_op_t       main_op;
    dual_ex_pkg::ex_op_t       dep_op;
    dual_ex_pkg::ex_result_t   main_res;
    dual_ex_pkg::ex_result_t   dep_res;
    dual_ex_pkg::pc_t          main_target;
    dual_ex_pkg::pc_t          dep_target;
    dual_ex_pkg::result_pair_t res_d;
    dual_ex_pkg::result_pair_t res_q;
    logic                      res_valid_q;
    logic                      out_free;
    logic                      accept;
    logic                      main_busy;
    logic                      main_done;
    logic                      main_taken;
    logic                      dep_taken;
    logic                      main_sel;
    logic                      main_lt;
    logic                      dep_lt;
    logic                      main_wins;
    logic                      dep_wins;

    // nothing else can fill the output register while a MUL runs
    assign out_free     = !res_valid_q || res_ready_i;
    assign pair_ready_o = !main_busy && out_free;
    assign accept       = pair_valid_i && pair_ready_o;

    // during a MUL both pipes work from the held pair
    assign cur_pair = main_busy ? hold_q : pair_i;

    // MUL always goes to the main pipe
    assign main_sel = cur_pair[1].valid && (cur_pair[1].op == dual_ex_pkg::MUL);
    assign main_op  = main_sel ? cur_pair[1] : cur_pair[0];
    assign dep_op   = main_sel ? cur_pair[0] : cur_pair[1];

    main_alu #(.DATA_W(DATA_W)) u_main_alu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .start_i  (accept),
        .op_i     (main_op),
        .done_o   (main_done),
        .busy_o   (main_busy),
        .result_o (main_res),
        .taken_o  (main_taken),
        .target_o (main_target)
    );

    deputy_alu #(.DATA_W(DATA_W)) u_deputy_alu (
        .op_i     (dep_op),
        .result_o (dep_res),
        .taken_o  (dep_taken),
        .target_o (dep_target)
    );

    // older taken branch wins, younger partner is squashed
    assign main_lt   = main_op.pc < dep_op.pc;
    assign dep_lt    = dep_op.pc < main_op.pc;
    assign main_wins = main_taken && (!dep_taken || main_lt);
    assign dep_wins  = dep_taken && !main_wins;

    always_comb begin
        res_d.main_res         = main_res;
        res_d.deputy_res       = dep_res;
        res_d.main_res.valid   = main_res.valid && !(dep_wins && dep_lt);
        res_d.deputy_res.valid = dep_res.valid && !(main_wins && main_lt);
        res_d.redirect_valid   = main_wins || dep_wins;
        res_d.redirect_pc      = main_wins ? main_target : (dep_wins ? dep_target : '0);
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q <= pair_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (main_done) begin
            res_valid_q <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (main_done) begin
            res_q <= res_d;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

/* src/issue_port.sv */
`timescale 1ns/1ps

module issue_port (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  issue_req_i,
    input  dual_ex_pkg::op_pair_t pair_i,
    input  logic                  pair_ready_i,
    output logic                  issue_ack_o,
    output logic                  pair_valid_o,
    output dual_ex_pkg::op_pair_t pair_o
);

    dual_ex_pkg::pipe_state_e state_q;
    dual_ex_pkg::op_pair_t    buf_q;
    logic                     buf_valid_q;
    logic                     capture;

    // only take a new pair into an empty buffer
    assign capture = (state_q == dual_ex_pkg::IDLE) && issue_req_i && !buf_valid_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dual_ex_pkg::IDLE;
        end else begin
            case (state_q)
                dual_ex_pkg::IDLE: begin
                    if (capture) begin
                        state_q <= dual_ex_pkg::WAIT_DROP;
                    end
                end
                dual_ex_pkg::WAIT_DROP: begin
                    // hold ack until the source lets go of req
                    if (!issue_req_i) begin
                        state_q <= dual_ex_pkg::IDLE;
                    end
                end
                default: state_q <= dual_ex_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            buf_valid_q <= 1'b0;
        end else if (capture) begin
            buf_valid_q <= 1'b1;
        end else if (buf_valid_q && pair_ready_i) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_q <= pair_i;
        end
    end

    assign issue_ack_o  = (state_q == dual_ex_pkg::WAIT_DROP);
    assign pair_valid_o = buf_valid_q;
    assign pair_o       = buf_q;

endmodule

/* src/main_alu.sv */
`timescale 1ns/1ps

module main_alu #(
    parameter int DATA_W = dual_ex_pkg::DATA_W_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  dual_ex_pkg::ex_op_t     op_i,
    output logic                    done_o,
    output logic                    busy_o,
    output dual_ex_pkg::ex_result_t result_o,
    output logic                    taken_o,
    output dual_ex_pkg::pc_t        target_o
);

    localparam int SHAMT_W = $clog2(DATA_W);

    dual_ex_pkg::pipe_state_e state_q;
    logic [SHAMT_W-1:0]       cnt_q;
    dual_ex_pkg::word_t       mcand_q;
    dual_ex_pkg::word_t       mplier_q;
    dual_ex_pkg::word_t       acc_q;
    dual_ex_pkg::word_t       acc_next;
    dual_ex_pkg::word_t       shamt;
    logic                     is_mul;
    logic                     mul_start;
    logic                     mul_last;

    assign is_mul    = op_i.valid && (op_i.op == dual_ex_pkg::MUL);
    assign mul_start = (state_q == dual_ex_pkg::IDLE) && start_i && is_mul;
    assign mul_last  = (state_q == dual_ex_pkg::BUSY) && (cnt_q == SHAMT_W'(DATA_W - 1));
    assign shamt     = dual_ex_pkg::word_t'(op_i.src_b[SHAMT_W-1:0]);

    // one partial product per cycle
    assign acc_next = acc_q + (mplier_q[0] ? mcand_q : '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dual_ex_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                dual_ex_pkg::IDLE: begin
                    if (mul_start) begin
                        state_q <= dual_ex_pkg::BUSY;
                        cnt_q   <= '0;
                    end
                end
                dual_ex_pkg::BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (mul_last) begin
                        state_q <= dual_ex_pkg::IDLE;
                    end
                end
                default: state_q <= dual_ex_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand_q  <= op_i.src_a;
            mplier_q <= op_i.src_b;
            acc_q    <= '0;
        end else if (state_q == dual_ex_pkg::BUSY) begin
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            acc_q    <= acc_next;
        end
    end

    assign busy_o = (state_q == dual_ex_pkg::BUSY);

    // single-cycle ops finish in the start cycle
    assign done_o = ((state_q == dual_ex_pkg::IDLE) && start_i && !is_mul) || mul_last;

    always_comb begin
        result_o.dest = op_i.dest;
        if (state_q == dual_ex_pkg::BUSY) begin
            result_o.valid = op_i.valid;
            result_o.value = acc_next;
        end else begin
            result_o.valid = op_i.valid && dual_ex_pkg::is_alu_op(op_i.op);
            result_o.value = dual_ex_pkg::alu_calc(op_i.op, op_i.src_a, op_i.src_b, shamt);
        end
    end

    assign taken_o  = op_i.valid && dual_ex_pkg::branch_cond(op_i.op, op_i.src_a, op_i.src_b);
    assign target_o = op_i.pc + op_i.imm;

endmodule

/* src/result_port.sv */
`timescale 1ns/1ps

module result_port (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      res_valid_i,
    input  dual_ex_pkg::result_pair_t res_i,
    input  logic                      res_ack_i,
    output logic                      res_ready_o,
    output logic                      res_req_o,
    output dual_ex_pkg::result_pair_t res_o
);

    dual_ex_pkg::pipe_state_e  state_q;
    dual_ex_pkg::result_pair_t out_q;
    logic                      take;

    assign res_ready_o = (state_q == dual_ex_pkg::IDLE);
    assign take        = res_ready_o && res_valid_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dual_ex_pkg::IDLE;
        end else begin
            case (state_q)
                dual_ex_pkg::IDLE: begin
                    if (take) begin
                        state_q <= dual_ex_pkg::WAIT_ACK;
                    end
                end
                dual_ex_pkg::WAIT_ACK: begin
                    if (res_ack_i) begin
                        state_q <= dual_ex_pkg::WAIT_DROP;
                    end
                end
                dual_ex_pkg::WAIT_DROP: begin
                    // sink must release ack before the next packet
                    if (!res_ack_i) begin
                        state_q <= dual_ex_pkg::IDLE;
                    end
                end
                default: state_q <= dual_ex_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_q <= res_i;
        end
    end

    assign res_req_o = (state_q == dual_ex_pkg::WAIT_ACK);
    assign res_o     = out_q;

endmodule
